//--- trng_pkg.sv
/*
  Shared widths, CRC constants and FSM encodings for the TRNG entropy path.
  CRC_POLY and CRC_INIT are 32-bit, so the seed length is meant to stay 32.
  Raw block and seed vectors are sized by module parameters, not here.
*/
`default_nettype none

package trng_pkg;

    //------------------------------------------------------------
    // Default top-level parameter values
    //------------------------------------------------------------
    localparam int RAW_BITS_DEF   = 64;   // Raw block length in bits
    localparam int SEED_BITS_DEF  = 32;   // Seed length, one CRC-32 word
    localparam int REP_LIMIT_DEF  = 8;    // Run length that fails the health test
    localparam int FIFO_DEPTH_DEF = 4;    // Seeds held in the output buffer

    //------------------------------------------------------------
    // CRC-32 constants
    //------------------------------------------------------------
    localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;  // Normal form, MSB first
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;  // All ones, no final XOR

    //------------------------------------------------------------
    // Vector types
    //------------------------------------------------------------
    typedef logic [7:0] byte_t;        // Host output byte
    typedef logic [7:0] fail_count_t;  // Saturating health failure count

    // Conditioner FSM
    typedef enum logic [1:0] {
        IDLE,   // Waiting for a raw block
        SHIFT,  // Bit-serial CRC over the block
        HOLD    // Seed ready, waiting on the buffer
    } cond_state_t;

    // Output buffer FSM
    typedef enum logic {
        WAIT,   // Idle, listening for host requests
        SEND    // Streaming bytes of the popped seed
    } buf_state_t;

endpackage

`default_nettype wire

//--- entropy_health_monitor.sv
/*
  Collects strobed entropy bits into raw blocks, first bit ends up as MSB.
  Repetition count test only: a run reaching REP_LIMIT discards the partial block.
  Strobes arriving while a full block waits for raw_ready_i are dropped.
  REP_LIMIT must be at least 1 and RAW_BITS at least 2.
*/
`timescale 1ns/1ps
`default_nettype none

module entropy_health_monitor import trng_pkg::*; #(
    parameter int RAW_BITS  = RAW_BITS_DEF,
    parameter int REP_LIMIT = REP_LIMIT_DEF
) (
    input  wire logic                clk,
    input  wire logic                reset_i,           // Sync, active high
    input  wire logic                entropy_bit_i,     // Raw bit from the source
    input  wire logic                entropy_strobe_i,  // Qualifies entropy_bit_i
    input  wire logic                raw_ready_i,       // From conditioner
    output logic                     raw_valid_o,       // Full block on raw_block_o
    output logic [RAW_BITS-1:0]      raw_block_o,
    output fail_count_t              fail_count_o       // Saturates at 255
);

    localparam int RUN_W = $clog2(REP_LIMIT + 1);
    localparam int CNT_W = $clog2(RAW_BITS);

    logic                accept;     // Strobe taken into the block
    logic                rep_fail;   // This bit completes a failing run
    logic [RUN_W-1:0]    run_q;      // Length of the current run, 0 after a failure
    logic [RUN_W-1:0]    run_next;
    logic                prev_q;     // Last accepted bit
    logic [CNT_W-1:0]    cnt_q;      // Bits already in the block
    logic [RAW_BITS-1:0] block_q;
    logic                valid_q;
    fail_count_t         fail_q;

    assign accept = entropy_strobe_i && !valid_q;  // Drop bits while a block waits

    // Run length including the incoming bit
    always_comb begin
        if (run_q != '0 && entropy_bit_i == prev_q) begin
            run_next = run_q + 1'b1;
        end else begin
            run_next = RUN_W'(1);  // New run
        end
    end

    assign rep_fail = accept && (run_next == RUN_W'(REP_LIMIT));

    //------------------------------------------------------------
    // Control: run tracking, bit count, failure count, valid
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            run_q   <= '0;
            prev_q  <= 1'b0;
            cnt_q   <= '0;
            fail_q  <= '0;
        end else begin
            if (valid_q && raw_ready_i) valid_q <= 1'b0;  // Block handed over
            if (accept) begin
                prev_q <= entropy_bit_i;
                if (rep_fail) begin
                    run_q <= '0;                       // Next bit starts a run of 1
                    cnt_q <= '0;                       // Partial block discarded
                    if (fail_q != '1) fail_q <= fail_q + 1'b1;
                end else begin
                    run_q <= run_next;                 // Run carries into next block
                    if (cnt_q == CNT_W'(RAW_BITS - 1)) begin
                        cnt_q   <= '0;
                        valid_q <= 1'b1;               // Block complete
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
            end
        end
    end

    // Block shift register, stale bits are pushed out by the next block
    always_ff @(posedge clk) begin
        if (accept && !rep_fail) block_q <= {block_q[RAW_BITS-2:0], entropy_bit_i};
    end

    assign raw_valid_o  = valid_q;
    assign raw_block_o  = block_q;
    assign fail_count_o = fail_q;

    // A presented block keeps its data and valid until the conditioner takes it
    a_block_held: assert property (@(posedge clk) disable iff (reset_i)
        (raw_valid_o && !raw_ready_i) |=> (raw_valid_o && $stable(raw_block_o)))
        else $error("raw block changed before transfer");

endmodule

`default_nettype wire

//--- crc_conditioner.sv
/*
  Compresses one raw block into a seed with a bit-serial CRC-32, one bit per cycle.
  Seed is the CRC register after RAW_BITS bits, MSB first, no final inversion.
  SEED_BITS is expected to be 32 to match CRC_POLY.
*/
`timescale 1ns/1ps
`default_nettype none

module crc_conditioner import trng_pkg::*; #(
    parameter int RAW_BITS  = RAW_BITS_DEF,
    parameter int SEED_BITS = SEED_BITS_DEF
) (
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire logic                 raw_valid_i,   // From health monitor
    input  wire logic [RAW_BITS-1:0]  raw_block_i,
    input  wire logic                 seed_ready_i,  // Buffer not full
    output logic                      raw_ready_o,   // Only in IDLE
    output logic                      seed_valid_o,  // Only in HOLD
    output logic [SEED_BITS-1:0]      seed_o
);

    localparam int                   CNT_W = $clog2(RAW_BITS);
    localparam logic [SEED_BITS-1:0] POLY  = SEED_BITS'(CRC_POLY);
    localparam logic [SEED_BITS-1:0] INIT  = SEED_BITS'(CRC_INIT);

    cond_state_t          state_q;
    logic [CNT_W-1:0]     cnt_q;     // Bits fed so far
    logic [RAW_BITS-1:0]  shreg_q;   // Block, consumed from the MSB
    logic [SEED_BITS-1:0] crc_q;
    logic                 fb;        // CRC feedback bit

    assign fb = crc_q[SEED_BITS-1] ^ shreg_q[RAW_BITS-1];

    //------------------------------------------------------------
    // FSM and bit counter
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: if (raw_valid_i) begin
                    state_q <= SHIFT;
                    cnt_q   <= '0;
                end
                SHIFT: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(RAW_BITS - 1)) state_q <= HOLD;  // Last bit in
                end
                HOLD: if (seed_ready_i) state_q <= IDLE;  // Seed accepted
                default: state_q <= IDLE;
            endcase
        end
    end

    // Datapath, capture then shift with the LFSR
    always_ff @(posedge clk) begin
        case (state_q)
            IDLE: if (raw_valid_i) begin
                shreg_q <= raw_block_i;
                crc_q   <= INIT;
            end
            SHIFT: begin
                shreg_q <= shreg_q << 1;
                crc_q   <= {crc_q[SEED_BITS-2:0], 1'b0} ^ (fb ? POLY : '0);
            end
            default: ;  // Hold seed
        endcase
    end

    assign raw_ready_o  = (state_q == IDLE);
    assign seed_valid_o = (state_q == HOLD);
    assign seed_o       = crc_q;

    // Block in, then RAW_BITS busy cycles, then the seed is offered
    a_seed_latency: assert property (@(posedge clk) disable iff (reset_i)
        (raw_valid_i && raw_ready_o)
            |=> (!raw_ready_o && !seed_valid_o) [*RAW_BITS] ##1 (seed_valid_o && !raw_ready_o))
        else $error("conditioner latency or ready violated");

endmodule

`default_nettype wire

//--- seed_byte_buffer.sv
/*
  Circular FIFO of seeds, each host request pops one and sends it as bytes.
  Bytes go out MSB first on SEED_BITS/8 consecutive cycles after the request.
  Requests while empty or mid-burst are ignored. SEED_BITS must be a multiple of 8.
*/
`timescale 1ns/1ps
`default_nettype none

module seed_byte_buffer import trng_pkg::*; #(
    parameter int SEED_BITS  = SEED_BITS_DEF,
    parameter int FIFO_DEPTH = FIFO_DEPTH_DEF
) (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  seed_valid_i,  // From conditioner
    input  wire logic [SEED_BITS-1:0]  seed_i,
    input  wire logic                  rand_req_i,    // One-cycle host pulse
    output logic                       seed_ready_o,  // FIFO not full
    output byte_t                      rand_byte_o,
    output logic                       rand_valid_o,
    output logic                       rand_empty_o   // No seed stored
);

    localparam int NBYTES = SEED_BITS / 8;
    localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
    localparam int BCNT_W = (NBYTES > 1) ? $clog2(NBYTES) : 1;

    logic [SEED_BITS-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]     wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0]     count_q;     // Seeds stored
    logic                 push, pop;
    buf_state_t           state_q;
    logic [SEED_BITS-1:0] out_q;       // Seed being sent, top byte first
    logic [BCNT_W-1:0]    bcnt_q;      // Bytes already sent

    assign seed_ready_o = (count_q != CNT_W'(FIFO_DEPTH));
    assign rand_empty_o = (count_q == '0);
    assign push = seed_valid_i && seed_ready_o;
    assign pop  = rand_req_i && (state_q == WAIT) && !rand_empty_o;

    //------------------------------------------------------------
    // FIFO pointers and occupancy
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            if (push && !pop)      count_q <= count_q + 1'b1;
            else if (pop && !push) count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr_q] <= seed_i;  // Storage, no reset
    end

    //------------------------------------------------------------
    // Burst FSM
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= WAIT;
            bcnt_q  <= '0;
        end else begin
            case (state_q)
                WAIT: if (pop) begin
                    state_q <= SEND;
                    bcnt_q  <= '0;
                end
                SEND: begin
                    bcnt_q <= bcnt_q + 1'b1;
                    if (bcnt_q == BCNT_W'(NBYTES - 1)) state_q <= WAIT;  // Last byte out
                end
                default: state_q <= WAIT;
            endcase
        end
    end

    // Output shifter, loads on pop, moves one byte per SEND cycle
    always_ff @(posedge clk) begin
        if (pop)                    out_q <= mem[rd_ptr_q];
        else if (state_q == SEND)   out_q <= out_q << 8;
    end

    assign rand_valid_o = (state_q == SEND);
    assign rand_byte_o  = out_q[SEED_BITS-1 -: 8];

    // Pointers meet only when the FIFO is empty or full
    a_ptr_count: assert property (@(posedge clk) disable iff (reset_i)
        (wr_ptr_q == rd_ptr_q) == (count_q == '0 || count_q == CNT_W'(FIFO_DEPTH)))
        else $error("seed FIFO count and pointers disagree");

    // Empty FIFO never starts a burst
    a_no_underflow: assert property (@(posedge clk) disable iff (reset_i)
        (rand_empty_o && state_q == WAIT) |=> !rand_valid_o)
        else $error("burst started from empty FIFO");

    // Every pop gives exactly NBYTES valid cycles, back to back
    a_burst_len: assert property (@(posedge clk) disable iff (reset_i)
        pop |=> rand_valid_o [*NBYTES] ##1 !rand_valid_o)
        else $error("burst length wrong");

endmodule

`default_nettype wire

//--- trng_top.sv
/*
  Entropy path top: health monitor, CRC conditioner, seed byte buffer.
  Parameters are set here and passed down; end-to-end latency depends on back-pressure.
*/
`timescale 1ns/1ps
`default_nettype none

module trng_top import trng_pkg::*; #(
    parameter int RAW_BITS   = RAW_BITS_DEF,
    parameter int SEED_BITS  = SEED_BITS_DEF,
    parameter int REP_LIMIT  = REP_LIMIT_DEF,
    parameter int FIFO_DEPTH = FIFO_DEPTH_DEF
) (
    input  wire logic  clk,
    input  wire logic  reset_i,
    input  wire logic  entropy_bit_i,      // Serial raw bit
    input  wire logic  entropy_strobe_i,   // Bit qualifier
    input  wire logic  rand_req_i,         // Host byte-burst request
    output byte_t      rand_byte_o,
    output logic       rand_valid_o,
    output logic       rand_empty_o,
    output fail_count_t health_fail_count_o
);

    //------------------------------------------------------------
    // Handshakes between stages
    //------------------------------------------------------------
    logic                 raw_valid, raw_ready;    // Monitor to conditioner
    logic [RAW_BITS-1:0]  raw_block;
    logic                 seed_valid, seed_ready;  // Conditioner to buffer
    logic [SEED_BITS-1:0] seed;

    entropy_health_monitor #(
        .RAW_BITS  (RAW_BITS),
        .REP_LIMIT (REP_LIMIT)
    ) u_monitor (
        .clk              (clk),
        .reset_i          (reset_i),
        .entropy_bit_i    (entropy_bit_i),
        .entropy_strobe_i (entropy_strobe_i),
        .raw_ready_i      (raw_ready),
        .raw_valid_o      (raw_valid),
        .raw_block_o      (raw_block),
        .fail_count_o     (health_fail_count_o)
    );

    crc_conditioner #(
        .RAW_BITS  (RAW_BITS),
        .SEED_BITS (SEED_BITS)
    ) u_conditioner (
        .clk          (clk),
        .reset_i      (reset_i),
        .raw_valid_i  (raw_valid),
        .raw_block_i  (raw_block),
        .seed_ready_i (seed_ready),
        .raw_ready_o  (raw_ready),
        .seed_valid_o (seed_valid),
        .seed_o       (seed)
    );

    seed_byte_buffer #(
        .SEED_BITS  (SEED_BITS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_buffer (
        .clk          (clk),
        .reset_i      (reset_i),
        .seed_valid_i (seed_valid),
        .seed_i       (seed),
        .rand_req_i   (rand_req_i),
        .seed_ready_o (seed_ready),   // Low when full, stalls the conditioner
        .rand_byte_o  (rand_byte_o),
        .rand_valid_o (rand_valid_o),
        .rand_empty_o (rand_empty_o)
    );

endmodule

`default_nettype wire

//--- trng_checker.sv
/*
  Checker for trng_top, samples DUT ports on the rising clock edge.
  Every strobe counts as accepted, so the stimulus must never stall the monitor.
  Models the repetition count test, the CRC-32 conditioner and the seed FIFO.
*/
`timescale 1ns/1ps
`default_nettype none

module trng_checker import trng_pkg::*; #(
    parameter int RAW_BITS  = RAW_BITS_DEF,
    parameter int SEED_BITS = SEED_BITS_DEF,
    parameter int REP_LIMIT = REP_LIMIT_DEF
) (
    input wire logic        clk,
    input wire logic        reset_i,
    input wire logic        entropy_bit_i,
    input wire logic        entropy_strobe_i,
    input wire byte_t       rand_byte_i,
    input wire logic        rand_valid_i,
    input wire logic        rand_empty_i,
    input wire fail_count_t fail_count_i
);

    localparam int NBYTES = SEED_BITS / 8;

    logic [SEED_BITS-1:0] exp_q [$];   // Seeds expected out, oldest first
    logic [SEED_BITS-1:0] cur_seed;    // Seed of the burst in flight
    logic [RAW_BITS-1:0]  blk;         // Model block register
    logic                 prev;
    logic                 have_seed;
    int                   run, cnt, nbyte, fail_model;
    int                   fail_start_model, fail_start_dut;
    string                test_name = "reset";
    int                   value_errors = 0;
    int                   protocol_errors = 0;

    // Reference CRC, MSB of the block first, no final inversion
    function automatic logic [SEED_BITS-1:0] crc_of(input logic [RAW_BITS-1:0] b);
        logic [SEED_BITS-1:0] c;
        logic                 fb;
        c = CRC_INIT[SEED_BITS-1:0];
        for (int i = RAW_BITS - 1; i >= 0; i--) begin
            fb = c[SEED_BITS-1] ^ b[i];
            c  = {c[SEED_BITS-2:0], 1'b0} ^ (fb ? CRC_POLY[SEED_BITS-1:0] : '0);
        end
        return c;
    endfunction

    //------------------------------------------------------------
    // Health test and block model
    //------------------------------------------------------------
    task automatic model_bit(input logic b);
        run  = (run != 0 && b == prev) ? run + 1 : 1;
        prev = b;
        if (run == REP_LIMIT) begin
            run = 0;                             // Fresh run on the next bit
            cnt = 0;                             // Partial block thrown away
            if (fail_model < 255) fail_model++;
        end else begin
            blk = {blk[RAW_BITS-2:0], b};
            cnt++;
            if (cnt == RAW_BITS) begin
                exp_q.push_back(crc_of(blk));    // Seed joins the FIFO model
                cnt = 0;
            end
        end
    endtask

    //------------------------------------------------------------
    // Burst model, one byte per valid cycle, top byte first
    //------------------------------------------------------------
    task automatic check_byte();
        logic [7:0] want;
        if (rand_valid_i) begin
            if (nbyte == 0) begin
                have_seed = (exp_q.size() != 0);
                if (have_seed) cur_seed = exp_q.pop_front();
                else begin
                    $display("Burst in %s started while no seed was expected", test_name);
                    protocol_errors++;
                end
            end
            if (nbyte < NBYTES && have_seed) begin
                want = cur_seed[SEED_BITS-1-8*nbyte -: 8];
                if (rand_byte_i !== want) begin
                    $display("Error: %s byte %0d expected %02h actual %02h",
                             test_name, nbyte, want, rand_byte_i);
                    value_errors++;
                end
            end else if (nbyte == NBYTES) begin
                $display("Burst in %s ran past %0d bytes", test_name, NBYTES);
                protocol_errors++;
            end
            nbyte++;
        end else begin
            if (nbyte != 0 && nbyte < NBYTES) begin
                $display("Burst in %s ended after %0d bytes", test_name, nbyte);
                protocol_errors++;
            end
            nbyte = 0;
        end
    endtask

    always @(posedge clk) begin
        if (reset_i) begin
            run        = 0;
            cnt        = 0;
            prev       = 1'b0;
            nbyte      = 0;
            fail_model = 0;
            exp_q.delete();
        end else begin
            if (entropy_strobe_i) model_bit(entropy_bit_i);
            check_byte();
        end
    end

    //------------------------------------------------------------
    // Row hooks called by the testbench top
    //------------------------------------------------------------
    function automatic int pending_seeds();
        return exp_q.size();
    endfunction

    task automatic start_row(input string name);
        test_name        = name;
        fail_start_model = fail_model;
        fail_start_dut   = int'(fail_count_i);
    endtask

    // Negative exp_inc means the model decides the increase
    task automatic check_row(input int exp_inc);
        int want;
        int got;
        want = (exp_inc < 0) ? fail_model - fail_start_model : exp_inc;
        got  = int'(fail_count_i) - fail_start_dut;
        if (got != want) begin
            $display("Error: %s fail count increase expected %0d actual %0d",
                     test_name, want, got);
            value_errors++;
        end
        if (exp_q.size() == 0 && !rand_empty_i) begin
            $display("Buffer in %s reports a seed although none is left", test_name);
            protocol_errors++;
        end
    endtask

endmodule

`default_nettype wire

//--- tb_trng.sv
/*
  Testbench top for trng_top with default parameters.
  Strobes come four cycles apart and at most six blocks queue up, so none is dropped.
  Every burst gets a second request mid-burst, which the buffer must ignore.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_trng import trng_pkg::*; ();

    localparam int NROWS       = 6;
    localparam int K_RANDOM    = 0;
    localparam int K_ZERO      = 1;
    localparam int K_ONE       = 2;
    localparam int K_STUCK     = 3;     // Alternating with a run of ones at bits 20..27
    localparam int FILL_LIMIT  = 2000;  // Cycles for a seed to reach the buffer
    localparam int BURST_LIMIT = 20;

    logic        clk = 1'b0;
    logic        reset_i, entropy_bit, entropy_strobe, rand_req;
    byte_t       rand_byte;
    logic        rand_valid, rand_empty;
    fail_count_t fail_count;

    // Stimulus table, one row per test
    string  row_name [NROWS];
    int     row_kind [NROWS];
    int     row_bits [NROWS];
    int     row_reqs [NROWS];
    int     row_inc  [NROWS];    // -1 lets the checker model decide
    integer seed_var = 83519;
    int     timeouts = 0;

    always #10 clk = ~clk;

    trng_top trng_top_inst (
        .clk                 (clk),
        .reset_i             (reset_i),
        .entropy_bit_i       (entropy_bit),
        .entropy_strobe_i    (entropy_strobe),
        .rand_req_i          (rand_req),
        .rand_byte_o         (rand_byte),
        .rand_valid_o        (rand_valid),
        .rand_empty_o        (rand_empty),
        .health_fail_count_o (fail_count)
    );

    trng_checker u_checker (
        .clk              (clk),
        .reset_i          (reset_i),
        .entropy_bit_i    (entropy_bit),
        .entropy_strobe_i (entropy_strobe),
        .rand_byte_i      (rand_byte),
        .rand_valid_i     (rand_valid),
        .rand_empty_i     (rand_empty),
        .fail_count_i     (fail_count)
    );

    task automatic set_row(input int idx, input string name, input int kind,
                           input int bits, input int reqs, input int inc);
        row_name[idx] = name;
        row_kind[idx] = kind;
        row_bits[idx] = bits;
        row_reqs[idx] = reqs;
        row_inc[idx]  = inc;
    endtask

    function automatic logic next_bit(input int kind, input int i);
        int r;
        r = $random(seed_var);
        case (kind)
            K_ZERO:  return 1'b0;
            K_ONE:   return 1'b1;
            K_STUCK: return (i >= 20 && i < 28) ? 1'b1 : i[0];
            default: return r[0];
        endcase
    endfunction

    // One strobe, then three quiet cycles
    task automatic feed_bit(input logic b);
        @(posedge clk);
        entropy_bit    <= b;
        entropy_strobe <= 1'b1;
        @(posedge clk);
        entropy_strobe <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic pulse_request();
        @(posedge clk);
        rand_req <= 1'b1;
        @(posedge clk);
        rand_req <= 1'b0;
    endtask

    task automatic wait_for_seed(input string name);
        int t;
        t = 0;
        @(negedge clk);
        while (rand_empty && t < FILL_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (rand_empty) begin
            $display("Timeout in %s: no seed reached the buffer", name);
            timeouts++;
        end
    endtask

    //------------------------------------------------------------
    // Request a burst, poke it once more, wait for its end
    //------------------------------------------------------------
    task automatic read_burst(input string name);
        int t;
        pulse_request();
        t = 0;
        @(negedge clk);
        while (!rand_valid && t < BURST_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!rand_valid) begin
            $display("Timeout in %s: request gave no burst", name);
            timeouts++;
        end else begin
            pulse_request();                 // Lands mid-burst, must be ignored
            t = 0;
            @(negedge clk);
            while (rand_valid && t < BURST_LIMIT) begin
                @(negedge clk);
                t++;
            end
            if (rand_valid) begin
                $display("Timeout in %s: burst never ended", name);
                timeouts++;
            end
        end
    endtask

    initial begin
        reset_i        = 1'b1;
        entropy_bit    = 1'b0;
        entropy_strobe = 1'b0;
        rand_req       = 1'b0;
        set_row(0, "random_blocks",            K_RANDOM, 128, 2, -1);
        set_row(1, "zero_stream_empty_req",    K_ZERO,   64,  1, 8);
        set_row(2, "one_stream",               K_ONE,    64,  1, 8);
        set_row(3, "stuck_then_clean_block",   K_STUCK,  91,  1, 1);
        set_row(4, "six_blocks_back_pressure", K_RANDOM, 384, 6, -1);
        set_row(5, "random_tail",              K_RANDOM, 64,  2, -1);
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;

        for (int r = 0; r < NROWS && timeouts == 0; r++) begin
            u_checker.start_row(row_name[r]);
            for (int i = 0; i < row_bits[r]; i++) begin
                feed_bit(next_bit(row_kind[r], i));
            end
            for (int q = 0; q < row_reqs[r]; q++) begin
                if (u_checker.pending_seeds() > 0) begin
                    wait_for_seed(row_name[r]);
                    read_burst(row_name[r]);
                end else begin
                    pulse_request();         // Buffer empty, no burst may follow
                    repeat (3) @(negedge clk);
                end
            end
            @(negedge clk);
            u_checker.check_row(row_inc[r]);
        end

        $display("Checks done: %0d value errors, %0d protocol errors, %0d timeouts",
                 u_checker.value_errors, u_checker.protocol_errors, timeouts);
        if (u_checker.value_errors + u_checker.protocol_errors + timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
trng_pkg.sv
entropy_health_monitor.sv
crc_conditioner.sv
seed_byte_buffer.sv
trng_top.sv
trng_checker.sv
tb_trng.sv

//--- Bender.yml
package:
  name: trng

sources:
  - trng_pkg.sv
  - entropy_health_monitor.sv
  - crc_conditioner.sv
  - seed_byte_buffer.sv
  - trng_top.sv
  - target: test
    files:
      - trng_checker.sv
      - tb_trng.sv
